/* Bender.yml */
package:
  name: risc_core

sources:
  - verilog/isaPkg.sv
  - verilog/cpuPkg.sv
  - verilog/fetchStage.sv
  - verilog/decodeStage.sv
  - verilog/regFile.sv
  - verilog/executeStage.sv
  - verilog/memoryStage.sv
  - verilog/riscCore.sv
  - target: test
    files:
      - verification/riscCoreSva.sv
      - verification/riscCoreTb.sv

/* list.f */
verilog/isaPkg.sv
verilog/cpuPkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/regFile.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/riscCore.sv
verification/riscCoreSva.sv
verification/riscCoreTb.sv

/* verification/programInput.txt */
# P <word>: program word in hex, loaded from word address 0 upward
# R <reg> <value>: expected retire record, register in decimal, data in hex
P 04010005  # addi r1, r0, 5
P 0402fffd  # addi r2, r0, -3
P 00221800  # add r3, r1, r2 (stall on r2)
P 00222040  # sub r4, r1, r2
P 00222880  # and r5, r1, r2
P 002230c0  # or r6, r1, r2
P 00223900  # xor r7, r1, r2
P 00414140  # slt r8, r2, r1
P 00224940  # slt r9, r1, r2
P 00245180  # sll r10, r1, r4
P 004459c0  # srl r11, r2, r4
P 00210000  # add r0, r1, r1
P 00016000  # add r12, r0, r1
P 00226a00  # cmov r13, r1, r2
P 05ae000a  # addi r14, r13, 10 (stall on r13)
P 008c7a00  # cmov r15, r4, r12
P 08d000f0  # andi r16, r6, 0x00f0
P 0c318000  # ori r17, r1, 0x8000
P 04120040  # addi r18, r0, 0x40
P 16510000  # sw r17, 0(r18)
P 16430004  # sw r3, 4(r18)
P 12530000  # lw r19, 0(r18)
P 12540004  # lw r20, 4(r18)
P 0293a800  # add r21, r20, r19
P 18000001  # bz r0, +1 taken
P 04160001  # addi r22, r0, 1 flushed
P 18200001  # bz r1, +1 not taken
P 04160002  # addi r22, r0, 2
P 1c200001  # bnz r1, +1 taken
P 04170003  # flushed
P 1c000001  # bnz r0, +1 not taken
P 04170004  # addi r23, r0, 4
P 20400001  # bltz r2, +1 taken
P 04180005  # flushed
P 20200001  # bltz r1, +1 not taken
P 04180006  # addi r24, r0, 6
P 24200001  # bgez r1, +1 taken
P 04190007  # flushed
P 24400001  # bgez r2, +1 not taken
P 04190008  # addi r25, r0, 8
P 28000002  # jump +2
P 041a0009  # flushed
P 041b000a  # never issued
P 041a000b  # addi r26, r0, 11
P 041c0003  # addi r28, r0, 3
P 07bd0001  # loop: addi r29, r29, 1
P 079cffff  # addi r28, r28, -1
P 1f80fffd  # bnz r28, loop
P fc000000  # halt
R 1 00000005
R 2 fffffffd
R 3 00000002
R 4 00000008
R 5 00000005
R 6 fffffffd
R 7 fffffff8
R 8 00000001
R 9 00000000
R 10 00000500
R 11 00ffffff
R 12 00000005
R 13 fffffffd
R 14 00000007
R 15 00000005
R 16 000000f0
R 17 ffff8005
R 18 00000040
R 19 ffff8005
R 20 00000002
R 21 ffff8007
R 22 00000002
R 23 00000004
R 24 00000006
R 25 00000008
R 26 0000000b
R 28 00000003
R 29 00000001
R 28 00000002
R 29 00000002
R 28 00000001
R 29 00000003
R 28 00000000

/* verification/riscCoreSva.sv */
`timescale 1ns/1ps
`default_nettype none

module riscCoreSva (
    input logic           clk,
    input logic           rstN,
    input logic           retireValid,
    input isaPkg::regIdxT retireReg,
    input logic           halted
);
    int failCount = 0;  // Total of failed assertions

    // Writes to r0 are dropped before the retire report
    retireNotZero: assert property (@(posedge clk) disable iff (!rstN)
        retireValid |-> retireReg != '0)
        else begin
            failCount++;
            $error("Retire reported register zero");
        end

    haltedSticky: assert property (@(posedge clk) disable iff (!rstN)
        halted |=> halted)
        else begin
            failCount++;
            $error("halted fell after rising");
        end

    // Everything has drained by the time halted rises
    noRetireHalted: assert property (@(posedge clk) disable iff (!rstN)
        halted |-> !retireValid)
        else begin
            failCount++;
            $error("Retire reported while halted");
        end

    quietInReset: assert property (@(posedge clk)
        !rstN |-> !retireValid)
        else begin
            failCount++;
            $error("Retire valid during reset");
        end

endmodule

bind riscCore riscCoreSva u_riscCoreSva (.*);

`default_nettype wire

/* verification/riscCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module riscCoreTb;
    import isaPkg::*;
    import cpuPkg::*;

    localparam int    imemWords   = 256;
    localparam int    dmemWords   = 256;
    localparam int    addrW       = $clog2(imemWords);
    localparam int    resetCycles = 4;
    localparam string inputPath   = "verification/programInput.txt";

    logic             clk;
    logic             rstN;
    logic             intr;
    logic             imemWe;
    logic [addrW-1:0] imemAddr;
    wordT             imemData;
    logic             retireValid;
    regIdxT           retireReg;
    wordT             retireData;
    logic             halted;

    wordT   progWords [$];
    regIdxT expReg [$];      // Expected retire sequence, in program order
    wordT   expData [$];
    integer seed;
    bit     fileOk;
    bit     timedOut = 1'b0;
    int     cycleCount = 0;
    int     timeoutLimit = 0;
    int     retireIdx = 0;
    int     mismatchCount = 0;
    int     otherErrors = 0;

    riscCore #(.imemWords(imemWords), .dmemWords(dmemWords)) u_riscCore (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic readProgramFile(output bit ok);
        int               fd;
        int               n;
        logic [7:0]       kind;
        wordT             word;
        regIdxT           regNum;
        logic [8*160-1:0] skipped;
        ok = 1'b0;
        fd = $fopen(inputPath, "r");
        if (fd == 0) begin
            $display("Cannot open the program file %s", inputPath);
        end else begin
            ok = 1'b1;
            n = $fscanf(fd, " %c", kind);
            while (n == 1) begin
                if (kind == "#") begin
                    n = $fgets(skipped, fd);  // Rest of a comment line
                end else if (kind == "P") begin
                    n = $fscanf(fd, "%h", word);
                    progWords.push_back(word);
                end else if (kind == "R") begin
                    n = $fscanf(fd, "%d %h", regNum, word);
                    expReg.push_back(regNum);
                    expData.push_back(word);
                end else begin
                    $display("Unknown record type in %s", inputPath);
                    ok = 1'b0;
                end
                n = ok ? $fscanf(fd, " %c", kind) : 0;
            end
            $fclose(fd);
            if (progWords.size() > imemWords || expReg.size() == 0) begin
                $display("Program file has no usable program or expected records");
                ok = 1'b0;
            end
        end
    endtask

    // One word per clock through the load port, fetch held by intr
    task automatic loadProgram();
        for (int i = 0; i < progWords.size(); i++) begin
            @(posedge clk);
            imemWe   <= 1'b1;
            imemAddr <= addrW'(i);
            imemData <= progWords[i];
        end
        @(posedge clk);
        imemWe <= 1'b0;
    endtask

    task automatic runWithPauses();
        @(posedge clk);
        intr <= 1'b0;
        while (!halted && !timedOut) begin
            @(posedge clk);
            intr <= (($random(seed) & 3) == 0);  // Pause about one cycle in four
        end
        intr <= 1'b0;
    endtask

    task automatic checkReg(input regIdxT got, input regIdxT exp, input int idx);
        if (got !== exp) begin
            mismatchCount++;
            $display("FAILED at time %0t: retire %0d wrote r%0d, expected r%0d",
                     $time, idx, got, exp);
        end
    endtask

    task automatic checkData(input wordT got, input wordT exp, input int idx);
        if (got !== exp) begin
            mismatchCount++;
            $display("FAILED at time %0t: retire %0d data %h, expected %h",
                     $time, idx, got, exp);
        end
    endtask

    // Retire outputs are registered, so sample away from the rising edge
    always @(negedge clk) begin
        if (rstN && retireValid) begin
            if (retireIdx < expReg.size()) begin
                checkReg(retireReg, expReg[retireIdx], retireIdx);
                checkData(retireData, expData[retireIdx], retireIdx);
            end else begin
                otherErrors++;
                $display("Extra retire of r%0d beyond the expected sequence", retireReg);
            end
            retireIdx++;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (timeoutLimit > 0 && cycleCount >= timeoutLimit && !timedOut) begin
            timedOut <= 1'b1;
            $display("Timeout: halted did not rise within %0d cycles", timeoutLimit);
        end
    end

    initial begin
        rstN     = 1'b0;
        intr     = 1'b1;
        imemWe   = 1'b0;
        imemAddr = '0;
        imemData = '0;
        seed     = 32'hc4fd_7391;
        readProgramFile(fileOk);
        timeoutLimit = expReg.size() * 8 + progWords.size() + resetCycles + 16;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        if (fileOk) begin
            loadProgram();
            runWithPauses();
            repeat (2) @(posedge clk);
            if (timedOut) otherErrors++;
            if (retireIdx != expReg.size()) begin
                otherErrors++;
                $display("Run ended after %0d of %0d expected retire records",
                         retireIdx, expReg.size());
            end
        end else begin
            otherErrors++;
        end
        otherErrors += u_riscCore.u_riscCoreSva.failCount;
        $display("Retire mismatches: %0d, other errors: %0d", mismatchCount, otherErrors);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    typedef logic [31:0] wordT;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluSlt   = 4'd5,  // Signed compare
        aluSll   = 4'd6,
        aluSrl   = 4'd7,
        aluPassB = 4'd8   // Used by cmov
    } aluOpT;

    // Branch condition, always on rs
    typedef enum logic [2:0] {
        brNone = 3'd0,
        brBz   = 3'd1,
        brBnz  = 3'd2,
        brBltz = 3'd3,
        brBgez = 3'd4,
        brJump = 3'd5
    } brOpT;

endpackage

`default_nettype wire

/* verilog/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  logic              clk,
    input  logic              rstN,
    input  logic              fdValid,
    input  isaPkg::instrWordT fdInstr,
    input  cpuPkg::wordT      fdNextPc,
    input  logic              exDestValid,
    input  isaPkg::regIdxT    exDestReg,
    output isaPkg::regIdxT    rs,
    output isaPkg::regIdxT    rt,
    input  cpuPkg::wordT      rdData1,
    input  cpuPkg::wordT      rdData2,
    input  logic              redirect,
    output logic              stall,
    output logic              deValid,
    output cpuPkg::wordT      deA,
    output cpuPkg::wordT      deB,
    output cpuPkg::wordT      deImm,
    output cpuPkg::aluOpT     deAluOp,
    output cpuPkg::brOpT      deBrOp,
    output logic              deAluSrc,
    output logic              deIsCmov,
    output logic              deMemRead,
    output logic              deMemWrite,
    output logic              deRegWrite,
    output isaPkg::regIdxT    deDestReg,
    output cpuPkg::wordT      deNextPc
);
    import isaPkg::*;
    import cpuPkg::*;

    opcodeT      opcode;
    funcT        func;
    regIdxT      rd;
    logic [25:0] jOffset;
    aluOpT       aluOp;
    brOpT        brOp;
    wordT        imm;
    logic        aluSrc;   // 1 selects register B
    logic        isCmov;
    logic        memRead;
    logic        memWrite;
    logic        regWrite;
    logic        useRd;
    logic        useRs;
    logic        useRt;
    logic        immJ;
    logic        isHalt;

    assign opcode  = fdInstr.iFormat.opcode;
    assign rs      = fdInstr.iFormat.rs;
    assign rt      = fdInstr.iFormat.rt;
    assign rd      = fdInstr.rFormat.rd;
    assign func    = fdInstr.rFormat.func;
    assign jOffset = {fdInstr.iFormat.rs, fdInstr.iFormat.rt, fdInstr.iFormat.imm16};

    always_comb begin
        aluOp    = aluAdd;
        brOp     = brNone;
        aluSrc   = 1'b0;
        isCmov   = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        regWrite = 1'b0;
        useRd    = 1'b0;
        useRs    = 1'b1;
        useRt    = 1'b0;
        immJ     = 1'b0;
        isHalt   = 1'b0;
        case (opcode)
            opR: begin
                aluSrc   = 1'b1;
                useRd    = 1'b1;
                useRt    = 1'b1;
                regWrite = 1'b1;
                case (func)
                    fnAdd:   aluOp = aluAdd;
                    fnSub:   aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnXor:   aluOp = aluXor;
                    fnSlt:   aluOp = aluSlt;
                    fnSll:   aluOp = aluSll;
                    fnSrl:   aluOp = aluSrl;
                    fnCmov: begin
                        aluOp  = aluPassB;  // Execute puts the minimum on B
                        isCmov = 1'b1;
                    end
                    default: regWrite = 1'b0;
                endcase
            end
            opAddi: regWrite = 1'b1;
            opAndi: begin
                aluOp    = aluAnd;
                regWrite = 1'b1;
            end
            opOri: begin
                aluOp    = aluOr;
                regWrite = 1'b1;
            end
            opLw: begin
                memRead  = 1'b1;
                regWrite = 1'b1;
            end
            opSw: begin
                memWrite = 1'b1;
                useRt    = 1'b1;  // Store data
            end
            opBz:   brOp = brBz;
            opBnz:  brOp = brBnz;
            opBltz: brOp = brBltz;
            opBgez: brOp = brBgez;
            opJump: begin
                brOp  = brJump;
                immJ  = 1'b1;
                useRs = 1'b0;
            end
            opHalt: begin
                isHalt = 1'b1;
                useRs  = 1'b0;
            end
            default: useRs = 1'b0;  // Unknown opcode runs as a no-op
        endcase
    end

    assign imm = immJ ? {{6{jOffset[25]}}, jOffset}
                      : {{16{fdInstr.iFormat.imm16[15]}}, fdInstr.iFormat.imm16};

    // No forwarding, so wait for the producer to reach writeback
    assign stall = fdValid && exDestValid
                   && ((useRs && rs == exDestReg) || (useRt && rt == exDestReg));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) deValid <= 1'b0;
        else       deValid <= fdValid && !stall && !redirect && !isHalt;
    end

    always_ff @(posedge clk) begin
        deA        <= rdData1;
        deB        <= rdData2;
        deImm      <= imm;
        deAluOp    <= aluOp;
        deBrOp     <= brOp;
        deAluSrc   <= aluSrc;
        deIsCmov   <= isCmov;
        deMemRead  <= memRead;
        deMemWrite <= memWrite;
        deRegWrite <= regWrite;
        deDestReg  <= useRd ? rd : rt;
        deNextPc   <= fdNextPc;
    end

endmodule

`default_nettype wire

/* verilog/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic           clk,
    input  logic           rstN,
    input  logic           deValid,
    input  cpuPkg::wordT   deA,
    input  cpuPkg::wordT   deB,
    input  cpuPkg::wordT   deImm,
    input  cpuPkg::aluOpT  deAluOp,
    input  cpuPkg::brOpT   deBrOp,
    input  logic           deAluSrc,
    input  logic           deIsCmov,
    input  logic           deMemRead,
    input  logic           deMemWrite,
    input  logic           deRegWrite,
    input  isaPkg::regIdxT deDestReg,
    input  cpuPkg::wordT   deNextPc,
    output logic           redirect,
    output cpuPkg::wordT   redirectPc,
    output logic           exDestValid,
    output isaPkg::regIdxT exDestReg,
    output logic           emValid,
    output cpuPkg::wordT   emResult,
    output cpuPkg::wordT   emStoreData,
    output logic           emMemRead,
    output logic           emMemWrite,
    output logic           emRegWrite,
    output isaPkg::regIdxT emDestReg
);
    import cpuPkg::*;

    wordT opA;
    wordT opB;
    wordT minAB;
    wordT result;
    logic isBranch;
    logic taken;

    assign isBranch = (deBrOp != brNone);
    assign minAB    = ($signed(deA) < $signed(deB)) ? deA : deB;
    assign opA      = isBranch ? deNextPc : deA;  // Targets are relative to next PC

    always_comb begin
        if (deIsCmov)      opB = minAB;
        else if (deAluSrc) opB = deB;
        else if (isBranch) opB = deImm << 2;  // Word offset
        else               opB = deImm;
    end

    always_comb begin
        case (deAluOp)
            aluAdd:   result = opA + opB;
            aluSub:   result = opA - opB;
            aluAnd:   result = opA & opB;
            aluOr:    result = opA | opB;
            aluXor:   result = opA ^ opB;
            aluSlt:   result = {31'b0, $signed(opA) < $signed(opB)};
            aluSll:   result = opA << opB[4:0];
            aluSrl:   result = opA >> opB[4:0];
            aluPassB: result = opB;
            default:  result = opA + opB;
        endcase
    end

    always_comb begin
        case (deBrOp)
            brBz:    taken = (deA == '0);
            brBnz:   taken = (deA != '0);
            brBltz:  taken = deA[31];
            brBgez:  taken = !deA[31];
            brJump:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect    = deValid && taken;
    assign redirectPc  = result;
    assign exDestValid = deValid && deRegWrite && (deDestReg != '0);
    assign exDestReg   = deDestReg;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) emValid <= 1'b0;
        else       emValid <= deValid;
    end

    always_ff @(posedge clk) begin
        emResult    <= result;
        emStoreData <= deB;
        emMemRead   <= deMemRead;
        emMemWrite  <= deMemWrite;
        emRegWrite  <= deRegWrite;
        emDestReg   <= deDestReg;
    end

endmodule

`default_nettype wire

/* verilog/fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
    parameter int imemWords = 256
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         intr,
    input  logic                         stall,
    input  logic                         redirect,
    input  cpuPkg::wordT                 redirectPc,
    input  logic                         pipeEmpty,
    input  logic                         imemWe,
    input  logic [$clog2(imemWords)-1:0] imemAddr,
    input  cpuPkg::wordT                 imemData,
    output logic                         fdValid,
    output isaPkg::instrWordT            fdInstr,
    output cpuPkg::wordT                 fdNextPc,
    output logic                         halted
);
    import isaPkg::*;
    import cpuPkg::*;

    localparam int addrW = $clog2(imemWords);

    wordT             imem [imemWords];
    wordT             pc;
    wordT             pcPlus4;
    logic [addrW-1:0] pcIdx;
    logic             haltSeen;   // Halt has reached decode
    logic             holdsHalt;
    logic             issue;

    assign pcPlus4   = pc + 32'd4;
    assign pcIdx     = pc[addrW+1:2];
    assign holdsHalt = fdValid && (fdInstr.iFormat.opcode == opHalt);
    assign issue     = !intr && !haltSeen && !holdsHalt;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc       <= '0;
            fdValid  <= 1'b0;
            haltSeen <= 1'b0;
            halted   <= 1'b0;
        end else begin
            if (redirect) begin
                pc      <= redirectPc;
                fdValid <= 1'b0;  // Drop the wrong-path word
            end else if (!stall) begin
                fdValid <= issue;
                if (issue) pc <= pcPlus4;
            end
            // A halt behind a taken branch is on the wrong path
            if (redirect) haltSeen <= 1'b0;
            else if (holdsHalt) haltSeen <= 1'b1;
            if (haltSeen && pipeEmpty) halted <= 1'b1;
        end
    end

    // Program load port and fetch register
    always_ff @(posedge clk) begin
        if (imemWe) imem[imemAddr] <= imemData;
        if (issue && !stall && !redirect) begin
            fdInstr  <= imem[pcIdx];
            fdNextPc <= pcPlus4;
        end
    end

endmodule

`default_nettype wire

/* verilog/isaPkg.sv */
`default_nettype none

package isaPkg;

    typedef logic [4:0] regIdxT;

    typedef enum logic [5:0] {
        opR    = 6'h00,  // Register format, operation in func
        opAddi = 6'h01,
        opAndi = 6'h02,
        opOri  = 6'h03,
        opLw   = 6'h04,
        opSw   = 6'h05,
        opBz   = 6'h06,  // Branches test rs only
        opBnz  = 6'h07,
        opBltz = 6'h08,
        opBgez = 6'h09,
        opJump = 6'h0a,  // J format
        opHalt = 6'h3f
    } opcodeT;

    typedef enum logic [4:0] {
        fnAdd  = 5'd0,
        fnSub  = 5'd1,
        fnAnd  = 5'd2,
        fnOr   = 5'd3,
        fnXor  = 5'd4,
        fnSlt  = 5'd5,
        fnSll  = 5'd6,   // Shift amount from rt
        fnSrl  = 5'd7,
        fnCmov = 5'd8    // rd gets the signed min of rs and rt
    } funcT;

    typedef struct packed {
        opcodeT     opcode;
        regIdxT     rs;
        regIdxT     rt;
        regIdxT     rd;
        funcT       func;
        logic [5:0] unused;
    } rFormatT;

    // J offset is {rs, rt, imm16} of this view
    typedef struct packed {
        opcodeT      opcode;
        regIdxT      rs;
        regIdxT      rt;
        logic [15:0] imm16;
    } iFormatT;

    typedef union packed {
        rFormatT rFormat;
        iFormatT iFormat;
    } instrWordT;

endpackage

`default_nettype wire

/* verilog/memoryStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryStage #(
    parameter int dmemWords = 256
) (
    input  logic           clk,
    input  logic           rstN,
    input  logic           emValid,
    input  cpuPkg::wordT   emResult,
    input  cpuPkg::wordT   emStoreData,
    input  logic           emMemRead,
    input  logic           emMemWrite,
    input  logic           emRegWrite,
    input  isaPkg::regIdxT emDestReg,
    output logic           wrEn,
    output isaPkg::regIdxT wrReg,
    output cpuPkg::wordT   wrData,
    output logic           retireValid,
    output isaPkg::regIdxT retireReg,
    output cpuPkg::wordT   retireData
);
    import cpuPkg::*;

    localparam int addrW = $clog2(dmemWords);

    wordT             dmem [dmemWords];
    wordT             loadData;
    logic [addrW-1:0] wordAddr;

    assign wordAddr = emResult[addrW+1:2];  // Byte address to word index
    assign loadData = dmem[wordAddr];

    always_ff @(posedge clk) begin
        if (emValid && emMemWrite) dmem[wordAddr] <= emStoreData;
    end

    assign wrEn   = emValid && emRegWrite && (emDestReg != '0);
    assign wrReg  = emDestReg;
    assign wrData = emMemRead ? loadData : emResult;

    // Retire report, one cycle after the register write
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) retireValid <= 1'b0;
        else       retireValid <= wrEn;
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            retireReg  <= wrReg;
            retireData <= wrData;
        end
    end

endmodule

`default_nettype wire

/* verilog/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic           clk,
    input  logic           rstN,
    input  isaPkg::regIdxT rs,
    input  isaPkg::regIdxT rt,
    output cpuPkg::wordT   rdData1,
    output cpuPkg::wordT   rdData2,
    input  logic           wrEn,
    input  isaPkg::regIdxT wrReg,
    input  cpuPkg::wordT   wrData
);
    import cpuPkg::*;

    wordT regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrReg != '0) begin  // r0 stays zero
            regs[wrReg] <= wrData;
        end
    end

    // Write in the same cycle is passed straight to the read
    assign rdData1 = (wrEn && wrReg == rs && rs != '0) ? wrData : regs[rs];
    assign rdData2 = (wrEn && wrReg == rt && rt != '0) ? wrData : regs[rt];

endmodule

`default_nettype wire

/* verilog/riscCore.sv */
`timescale 1ns/1ps
`default_nettype none

module riscCore #(
    parameter int imemWords = 256,
    parameter int dmemWords = 256
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         intr,       // Pause level for fetch
    input  logic                         imemWe,
    input  logic [$clog2(imemWords)-1:0] imemAddr,
    input  cpuPkg::wordT                 imemData,
    output logic                         retireValid,
    output isaPkg::regIdxT               retireReg,
    output cpuPkg::wordT                 retireData,
    output logic                         halted
);
    import isaPkg::*;
    import cpuPkg::*;

    logic      fdValid;
    instrWordT fdInstr;
    wordT      fdNextPc;
    logic      stall;
    logic      redirect;
    wordT      redirectPc;
    logic      pipeEmpty;

    regIdxT    rs;
    regIdxT    rt;
    wordT      rdData1;
    wordT      rdData2;

    logic      deValid;
    wordT      deA;
    wordT      deB;
    wordT      deImm;
    aluOpT     deAluOp;
    brOpT      deBrOp;
    logic      deAluSrc;
    logic      deIsCmov;
    logic      deMemRead;
    logic      deMemWrite;
    logic      deRegWrite;
    regIdxT    deDestReg;
    wordT      deNextPc;
    logic      exDestValid;
    regIdxT    exDestReg;

    logic      emValid;
    wordT      emResult;
    wordT      emStoreData;
    logic      emMemRead;
    logic      emMemWrite;
    logic      emRegWrite;
    regIdxT    emDestReg;

    logic      wrEn;
    regIdxT    wrReg;
    wordT      wrData;

    // Nothing left in flight ahead of writeback
    assign pipeEmpty = !fdValid && !deValid && !emValid;

    fetchStage #(.imemWords(imemWords)) u_fetchStage (.*);

    decodeStage u_decodeStage (.*);

    regFile u_regFile (.*);

    executeStage u_executeStage (.*);

    memoryStage #(.dmemWords(dmemWords)) u_memoryStage (.*);

endmodule

`default_nettype wire
